// File: include/tlb_defs.svh
/*
 * tlb sizing macros: entry count, index width and page/address field widths
 */
`ifndef TLB_DEFS_SVH
`define TLB_DEFS_SVH

// fully associative, eight ways
`define TLB_ENTRIES 8
`define TLB_IDX_W   3   // log2 of entry count

// 32-bit machine, 4 KB pages
`define TLB_VPN_W   20  // virtual page number
`define TLB_PFN_W   20  // page frame number
`define TLB_OFS_W   12  // byte offset inside a page
`define TLB_ADDR_W  32

`endif

// File: src/tlb_pkg.sv
/*
 * tlb package: page, frame, index and flag types shared by the tlb blocks
 */
`include "tlb_defs.svh"

package tlb_pkg;

    // virtual page number, the cam tag
    typedef logic [`TLB_VPN_W-1:0] vpn_t;

    // physical page frame number
    typedef logic [`TLB_PFN_W-1:0] pfn_t;

    typedef logic [`TLB_IDX_W-1:0] tlb_idx_t; // entry index, also the victim pointer

    // per-entry permission and attribute bits
    // valid lives outside this bundle, only the store and matchers care
    typedef struct packed {
        logic present; // page is resident
        logic rw;      // 1 = writable, 0 = read only
        logic pcd;     // page cache disable, set for mmio pages
    } tlb_flags_t;

    // translated address: frame number followed by page offset
    typedef logic [`TLB_ADDR_W-1:0] paddr_t;

endpackage

// File: src/onehot_select.sv
/*
 * one-hot multiplexer for any packed payload: or of the selected inputs,
 * zero when no select bit is set
 */
module onehot_select #(
    parameter type payload_t  = logic,
    parameter int  NUM_INPUTS = 2
) (
    input  payload_t               in [NUM_INPUTS],
    input  logic [NUM_INPUTS-1:0]  sel,   // one-hot or all zero
    output payload_t               out
);

    // and-or tree, replaces a tristate bus
    always_comb begin
        out = '0;
        for (int i = 0; i < NUM_INPUTS; i++) begin
            if (sel[i]) begin
                out = out | in[i];  // only one term is ever live
            end
        end
    end

    // two live selects would merge payloads silently
    always_comb begin
        sel_onehot: assert final ($onehot0(sel) || $isunknown(sel))
            else $error("onehot_select with more than one select bit");
    end

endmodule

// File: src/tlb_entry_store.sv
/*
 * tlb entry store: eight tag/frame/flag registers with one fill port and a
 * global flush, read out flat to the lookup and victim logic
 */
`include "tlb_defs.svh"

module tlb_entry_store (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   fill,       // one-cycle write strobe
    input  logic                   flush,      // one-cycle invalidate-all strobe
    input  tlb_pkg::tlb_idx_t      fill_idx,   // entry to write
    input  tlb_pkg::vpn_t          fill_vpn,
    input  tlb_pkg::pfn_t          fill_pfn,
    input  tlb_pkg::tlb_flags_t    fill_flags,
    output tlb_pkg::vpn_t          tag   [`TLB_ENTRIES],
    output tlb_pkg::pfn_t          frame [`TLB_ENTRIES],
    output tlb_pkg::tlb_flags_t    flags [`TLB_ENTRIES],
    output logic [`TLB_ENTRIES-1:0] entry_v
);

    logic do_write; // fill that survives a concurrent flush

    // flush wins over fill, the fill is simply lost
    assign do_write = fill && !flush;

    // valid bits are the only control state here
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            entry_v <= '0;                  // drop every translation
        end else if (fill) begin
            entry_v[fill_idx] <= 1'b1;      // new or refreshed entry becomes live
        end
    end

    // payload registers, written in place
    always_ff @(posedge clk) begin
        if (do_write) begin
            tag[fill_idx]   <= fill_vpn;
            frame[fill_idx] <= fill_pfn;
            flags[fill_idx] <= fill_flags;
        end
    end

    // the index comes from the victim selector, it has to be resolved
    // whenever a fill is presented
    fill_idx_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        fill |-> !$isunknown(fill_idx)
    ) else $error("tlb fill with unknown entry index");

endmodule

// File: src/tlb_victim_select.sv
/*
 * tlb victim selection: round-robin replacement pointer, overridden by the
 * index of an entry that already caches the page being filled
 */
`include "tlb_defs.svh"

module tlb_victim_select (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    fill,
    input  logic                    flush,
    input  tlb_pkg::vpn_t           fill_vpn,
    input  tlb_pkg::vpn_t           tag [`TLB_ENTRIES],
    input  logic [`TLB_ENTRIES-1:0] entry_v,
    output tlb_pkg::tlb_idx_t       fill_idx
);

    logic [`TLB_ENTRIES-1:0] refresh_hit; // which valid entry already holds fill_vpn
    logic                    refresh;
    tlb_pkg::tlb_idx_t       hit_idx;     // encoded refresh_hit
    tlb_pkg::tlb_idx_t       rr_ptr;      // next victim

    // private compare against the fill page, separate from the lookup path
    always_comb begin
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            refresh_hit[i] = entry_v[i] && (tag[i] == fill_vpn);
        end
    end

    assign refresh = |refresh_hit;

    // or-encoder, fine since at most one bit is set
    always_comb begin
        hit_idx = '0;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            if (refresh_hit[i]) hit_idx = hit_idx | tlb_pkg::tlb_idx_t'(i);
        end
    end

    assign fill_idx = refresh ? hit_idx : rr_ptr; // refresh in place, else evict

    // 3-bit pointer wraps 7 -> 0 on its own
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rr_ptr <= '0;
        end else if (fill && !flush && !refresh) begin
            rr_ptr <= rr_ptr + 1'b1;
        end
    end

    // the store never holds the same page twice, so a fill matches at most once
    refresh_onehot: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0(refresh_hit)
    ) else $error("tlb fill page cached in more than one entry");

endmodule

// File: src/tlb_lookup.sv
/*
 * tlb lookup for the mem stage: tag compare, frame and flag selection, and
 * the hit, miss, protection and physical address outputs, all combinational
 */
`include "tlb_defs.svh"

module tlb_lookup (
    input  logic [`TLB_ADDR_W-1:0] address,         // virtual address to translate
    input  logic                   rw_in,           // 1 = write access
    input  logic                   is_mem_request,  // no request, no exception
    input  tlb_pkg::vpn_t          tag   [`TLB_ENTRIES],
    input  tlb_pkg::pfn_t          frame [`TLB_ENTRIES],
    input  tlb_pkg::tlb_flags_t    flags [`TLB_ENTRIES],
    input  logic [`TLB_ENTRIES-1:0] entry_v,
    output tlb_pkg::paddr_t        paddr,
    output logic                   pcd_out,
    output logic                   hit,
    output logic                   miss,
    output logic                   protection_exception
);

    tlb_pkg::vpn_t           lookup_vpn;  // address bits 31:12
    logic [`TLB_ENTRIES-1:0] is_eq;       // valid-gated tag match, one-hot
    logic                    match;
    logic                    hit_gen;     // match on a present page
    tlb_pkg::pfn_t           frame_sel;
    tlb_pkg::tlb_flags_t     flags_sel;

    assign lookup_vpn = address[`TLB_ADDR_W-1:`TLB_OFS_W];

    // valid folded into the compare so stale duplicates never select
    always_comb begin
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            is_eq[i] = entry_v[i] && (tag[i] == lookup_vpn);
        end
    end

    assign match = |is_eq;

    onehot_select #(
        .payload_t  (tlb_pkg::pfn_t),
        .NUM_INPUTS (`TLB_ENTRIES)
    ) u_frame_sel (
        .in  (frame),
        .sel (is_eq),
        .out (frame_sel)   // zero on no match
    );

    onehot_select #(
        .payload_t  (tlb_pkg::tlb_flags_t),
        .NUM_INPUTS (`TLB_ENTRIES)
    ) u_flags_sel (
        .in  (flags),
        .sel (is_eq),
        .out (flags_sel)
    );

    // present check applied after the match
    assign hit_gen = match && flags_sel.present;

    // idle cycles report hit so the pipe never stalls on them
    assign hit  = !is_mem_request || hit_gen;
    assign miss = !hit;

    // write to a read-only page that otherwise hits
    assign protection_exception = is_mem_request && hit_gen && rw_in && !flags_sel.rw;

    assign paddr   = {frame_sel, address[`TLB_OFS_W-1:0]}; // offset passes straight through
    assign pcd_out = flags_sel.pcd;

    // a live request needs a resolved address and access type to translate
    always_comb begin
        request_known: assert final (
            (is_mem_request !== 1'b1) || !$isunknown({address, rw_in})
        ) else $error("tlb request with unknown address or access type");
    end

endmodule

// File: src/mmu_tlb_top.sv
/*
 * eight-entry fully associative tlb: entry store, round-robin victim
 * selection with refresh, and the combinational mem-stage lookup
 */
`include "tlb_defs.svh"

module mmu_tlb_top (
    input  logic                   clk,
    input  logic                   rst_n,
    // lookup, levels
    input  logic [`TLB_ADDR_W-1:0] address,
    input  logic                   rw_in,
    input  logic                   is_mem_request,
    // fill, qualified by the fill strobe
    input  logic                   fill,
    input  tlb_pkg::vpn_t          fill_vpn,
    input  tlb_pkg::pfn_t          fill_pfn,
    input  logic                   fill_present,
    input  logic                   fill_rw,
    input  logic                   fill_pcd,
    input  logic                   flush,
    // translation result
    output tlb_pkg::paddr_t        paddr,
    output logic                   pcd_out,
    output logic                   hit,
    output logic                   miss,
    output logic                   protection_exception
);

    tlb_pkg::tlb_flags_t     fill_flags;
    tlb_pkg::tlb_idx_t       fill_idx;              // victim or refresh slot
    tlb_pkg::vpn_t           tag   [`TLB_ENTRIES];
    tlb_pkg::pfn_t           frame [`TLB_ENTRIES];
    tlb_pkg::tlb_flags_t     flags [`TLB_ENTRIES];
    logic [`TLB_ENTRIES-1:0] entry_v;

    assign fill_flags = '{present: fill_present, rw: fill_rw, pcd: fill_pcd};

    tlb_entry_store u_store (
        .clk        (clk),
        .rst_n      (rst_n),
        .fill       (fill),
        .flush      (flush),
        .fill_idx   (fill_idx),
        .fill_vpn   (fill_vpn),
        .fill_pfn   (fill_pfn),
        .fill_flags (fill_flags),
        .tag        (tag),
        .frame      (frame),
        .flags      (flags),
        .entry_v    (entry_v)
    );

    tlb_victim_select u_victim (
        .clk      (clk),
        .rst_n    (rst_n),
        .fill     (fill),
        .flush    (flush),
        .fill_vpn (fill_vpn),
        .tag      (tag),
        .entry_v  (entry_v),
        .fill_idx (fill_idx)
    );

    // reads the store as of the last edge
    tlb_lookup u_lookup (
        .address              (address),
        .rw_in                (rw_in),
        .is_mem_request       (is_mem_request),
        .tag                  (tag),
        .frame                (frame),
        .flags                (flags),
        .entry_v              (entry_v),
        .paddr                (paddr),
        .pcd_out              (pcd_out),
        .hit                  (hit),
        .miss                 (miss),
        .protection_exception (protection_exception)
    );

endmodule

// File: testbench/tb_mmu_tlb.sv
/*
 * tlb testbench: directed fill, lookup, refresh, protection and flush tests
 * checked against a behavioral model of the eight entries and the victim pointer
 */
`include "tlb_defs.svh"

module tb_mmu_tlb;

    localparam int MAX_CYCLES = 2000; // directed sequence runs a few hundred cycles at most

    logic                   clk;
    logic                   rst_n;
    logic [`TLB_ADDR_W-1:0] address;
    logic                   rw_in;
    logic                   is_mem_request;
    logic                   fill;
    tlb_pkg::vpn_t          fill_vpn;
    tlb_pkg::pfn_t          fill_pfn;
    logic                   fill_present;
    logic                   fill_rw;
    logic                   fill_pcd;
    logic                   flush;
    tlb_pkg::paddr_t        paddr;
    logic                   pcd_out;
    logic                   hit;
    logic                   miss;
    logic                   protection_exception;

    // reference model of the table
    tlb_pkg::vpn_t       m_vpn   [`TLB_ENTRIES];
    tlb_pkg::pfn_t       m_pfn   [`TLB_ENTRIES];
    tlb_pkg::tlb_flags_t m_flags [`TLB_ENTRIES];
    logic                m_valid [`TLB_ENTRIES];
    tlb_pkg::tlb_idx_t   m_ptr;    // wraps 7 -> 0 by width

    tlb_pkg::vpn_t used_vpns [$]; // every page handed out so far
    tlb_pkg::vpn_t pages     [$]; // pages of the fill/translate test
    int            errors;
    int            cycles;

    mmu_tlb_top dut (
        .clk                  (clk),
        .rst_n                (rst_n),
        .address              (address),
        .rw_in                (rw_in),
        .is_mem_request       (is_mem_request),
        .fill                 (fill),
        .fill_vpn             (fill_vpn),
        .fill_pfn             (fill_pfn),
        .fill_present         (fill_present),
        .fill_rw              (fill_rw),
        .fill_pcd             (fill_pcd),
        .flush                (flush),
        .paddr                (paddr),
        .pcd_out              (pcd_out),
        .hit                  (hit),
        .miss                 (miss),
        .protection_exception (protection_exception)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk; // period 8
    end

    // run limit
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic check_paddr(input string name, input tlb_pkg::paddr_t got,
                               input tlb_pkg::paddr_t exp);
        if (got !== exp) begin
            errors = errors + 1;
            $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors = errors + 1;
            $display("Fail at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // random page never used before in this run
    function automatic tlb_pkg::vpn_t fresh_vpn();
        tlb_pkg::vpn_t v;
        logic          dup;
        do begin
            v   = tlb_pkg::vpn_t'($urandom);
            dup = 1'b0;
            foreach (used_vpns[k]) begin
                if (used_vpns[k] == v) dup = 1'b1;
            end
        end while (dup);
        used_vpns.push_back(v);
        return v;
    endfunction

    // one fill strobe, optionally with a flush in the same cycle
    task automatic write_entry(input tlb_pkg::vpn_t vpn, input tlb_pkg::pfn_t pfn,
                               input logic present, input logic wr, input logic pcd,
                               input logic with_flush);
        int slot;
        @(negedge clk);
        fill         = 1'b1;
        fill_vpn     = vpn;
        fill_pfn     = pfn;
        fill_present = present;
        fill_rw      = wr;
        fill_pcd     = pcd;
        flush        = with_flush;
        @(posedge clk);
        if (with_flush) begin
            foreach (m_valid[i]) m_valid[i] = 1'b0; // fill dropped, pointer stays
        end else begin
            slot = -1;
            foreach (m_vpn[i]) begin
                if (m_valid[i] && m_vpn[i] == vpn) slot = i; // refresh in place
            end
            if (slot < 0) begin
                slot  = m_ptr;
                m_ptr = m_ptr + 1'b1;
            end
            m_vpn[slot]   = vpn;
            m_pfn[slot]   = pfn;
            m_flags[slot] = '{present: present, rw: wr, pcd: pcd};
            m_valid[slot] = 1'b1;
        end
        @(negedge clk);
        fill  = 1'b0;
        flush = 1'b0;
    endtask

    task automatic flush_all();
        @(negedge clk);
        flush = 1'b1;
        @(posedge clk);
        foreach (m_valid[i]) m_valid[i] = 1'b0;
        @(negedge clk);
        flush = 1'b0;
    endtask

    // drive a lookup, then compare every output with the model
    task automatic lookup_check(input tlb_pkg::vpn_t vpn, input logic wr, input logic req);
        logic [`TLB_OFS_W-1:0] ofs;
        tlb_pkg::paddr_t       exp_paddr;
        logic                  exp_hit;
        logic                  exp_pcd;
        logic                  exp_pe;
        logic                  hit_gen;
        int                    idx;
        @(negedge clk);
        ofs            = `TLB_OFS_W'($urandom);
        address        = {vpn, ofs};
        rw_in          = wr;
        is_mem_request = req;
        #2; // settle, well before the next rising edge
        idx = -1;
        foreach (m_vpn[i]) begin
            if (m_valid[i] && m_vpn[i] == vpn) idx = i;
        end
        hit_gen   = (idx >= 0) && m_flags[idx].present;
        exp_hit   = !req || hit_gen;
        exp_pe    = req && hit_gen && wr && (idx >= 0) && !m_flags[idx].rw;
        exp_paddr = (idx >= 0) ? {m_pfn[idx], ofs} : {`TLB_PFN_W'(0), ofs};
        exp_pcd   = (idx >= 0) ? m_flags[idx].pcd : 1'b0;
        check_paddr("paddr", paddr, exp_paddr);
        check_bit("hit", hit, exp_hit);
        check_bit("miss", miss, !exp_hit);
        check_bit("protection_exception", protection_exception, exp_pe);
        check_bit("pcd_out", pcd_out, exp_pcd);
    endtask

    task automatic test_after_reset();
        lookup_check(tlb_pkg::vpn_t'($urandom), 1'b0, 1'b0); // idle reports hit
        lookup_check(tlb_pkg::vpn_t'($urandom), 1'b1, 1'b0);
        lookup_check(tlb_pkg::vpn_t'($urandom), 1'b0, 1'b1); // empty table misses
        lookup_check(tlb_pkg::vpn_t'($urandom), 1'b1, 1'b1);
    endtask

    task automatic test_fill_translate();
        tlb_pkg::vpn_t v;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            v = fresh_vpn();
            pages.push_back(v);
            write_entry(v, tlb_pkg::pfn_t'($urandom), 1'b1, $urandom % 2, $urandom % 2, 1'b0);
        end
        foreach (pages[i]) lookup_check(pages[i], 1'b0, 1'b1);
    endtask

    task automatic test_replace_refresh();
        // ninth page evicts entry 0
        write_entry(fresh_vpn(), tlb_pkg::pfn_t'($urandom), 1'b1, 1'b1, 1'b0, 1'b0);
        lookup_check(pages[0], 1'b0, 1'b1);
        lookup_check(used_vpns[used_vpns.size()-1], 1'b0, 1'b1);
        // refresh page 3 with a new frame, pointer must stay at 1
        write_entry(pages[3], tlb_pkg::pfn_t'($urandom), 1'b1, 1'b1, 1'b1, 1'b0);
        lookup_check(pages[3], 1'b0, 1'b1);
        lookup_check(pages[4], 1'b0, 1'b1);
        write_entry(fresh_vpn(), tlb_pkg::pfn_t'($urandom), 1'b1, 1'b0, 1'b0, 1'b0);
        lookup_check(pages[1], 1'b0, 1'b1); // evicted from entry 1
        lookup_check(pages[2], 1'b0, 1'b1);
        lookup_check(pages[3], 1'b0, 1'b1);
    endtask

    task automatic test_present_protect();
        tlb_pkg::vpn_t not_present;
        tlb_pkg::vpn_t read_only;
        tlb_pkg::vpn_t writable;
        not_present = fresh_vpn();
        read_only   = fresh_vpn();
        writable    = fresh_vpn();
        write_entry(not_present, tlb_pkg::pfn_t'($urandom), 1'b0, 1'b1, 1'b0, 1'b0);
        write_entry(read_only, tlb_pkg::pfn_t'($urandom), 1'b1, 1'b0, 1'b1, 1'b0);
        write_entry(writable, tlb_pkg::pfn_t'($urandom), 1'b1, 1'b1, 1'b0, 1'b0);
        lookup_check(not_present, 1'b0, 1'b1);
        lookup_check(not_present, 1'b1, 1'b1); // no exception without a hit
        lookup_check(read_only, 1'b1, 1'b1);   // write to read-only page
        lookup_check(read_only, 1'b0, 1'b1);
        lookup_check(read_only, 1'b1, 1'b0);   // idle write strobe ignored
        lookup_check(writable, 1'b1, 1'b1);
    endtask

    task automatic test_flush();
        flush_all();
        foreach (used_vpns[i]) lookup_check(used_vpns[i], 1'b0, 1'b1);
        // flush wins, the fill is lost
        write_entry(fresh_vpn(), tlb_pkg::pfn_t'($urandom), 1'b1, 1'b1, 1'b0, 1'b1);
        foreach (used_vpns[i]) lookup_check(used_vpns[i], 1'b0, 1'b1);
        // table still usable afterwards
        write_entry(fresh_vpn(), tlb_pkg::pfn_t'($urandom), 1'b1, 1'b1, 1'b1, 1'b0);
        lookup_check(used_vpns[used_vpns.size()-1], 1'b1, 1'b1);
    endtask

    initial begin
        void'($urandom(46570));
        errors         = 0;
        cycles         = 0;
        rst_n          = 1'b0;
        address        = '0;
        rw_in          = 1'b0;
        is_mem_request = 1'b0;
        fill           = 1'b0;
        fill_vpn       = '0;
        fill_pfn       = '0;
        fill_present   = 1'b0;
        fill_rw        = 1'b0;
        fill_pcd       = 1'b0;
        flush          = 1'b0;
        foreach (m_valid[i]) m_valid[i] = 1'b0;
        m_ptr = '0;
        repeat (3) @(posedge clk); // reset for three edges
        @(negedge clk);
        rst_n = 1'b1;

        test_after_reset();
        test_fill_translate();
        test_replace_refresh();
        test_present_protect();
        test_flush();

        $display("summary: %0d errors after %0d cycles", errors, cycles);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: mmu_tlb.f
+incdir+include
src/tlb_pkg.sv
src/onehot_select.sv
src/tlb_entry_store.sv
src/tlb_victim_select.sv
src/tlb_lookup.sv
src/mmu_tlb_top.sv
testbench/tb_mmu_tlb.sv
